//--- hw/dcache_config.svh
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// Cache geometry.
`define DCACHE_SETS  16
`define DCACHE_WAYS  2
`define DCACHE_WORDS 4

// Word and address width.
`define DCACHE_XLEN  32

`endif

//--- hw/dcache_pkg.sv
`include "dcache_config.svh"

package dcache_pkg;

    typedef logic [`DCACHE_XLEN-1:0] word_t;
    typedef word_t [`DCACHE_WORDS-1:0] line_t;

    typedef logic [$clog2(`DCACHE_SETS)-1:0] index_t;
    typedef logic [$clog2(`DCACHE_WORDS)-1:0] offset_t;
    typedef logic [`DCACHE_XLEN-$clog2(`DCACHE_SETS)-$clog2(`DCACHE_WORDS)-1:0] tag_t;
    typedef logic [$clog2(`DCACHE_WAYS)-1:0] way_t;

    // Word address split with the tag in the top bits.
    typedef struct packed {
        tag_t    tag;
        index_t  index;
        offset_t offset;
    } addr_fields_t;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  we;
    } core_req_t;

    typedef struct packed {
        word_t rdata;
    } core_rsp_t;

    typedef struct packed {
        word_t addr;  // Line aligned.
        logic  we;
        line_t wline;
    } mem_req_t;

    typedef struct packed {
        line_t line;
    } mem_rsp_t;

    typedef struct packed {
        logic  hit;
        way_t  hit_way;
        line_t hit_line;
        way_t  victim_way;
        logic  victim_valid;
        logic  victim_dirty;
        tag_t  victim_tag;
        line_t victim_line;
    } lookup_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITE_BACK,
        REFILL,
        RESPOND
    } ctrl_state_t;

endpackage

//--- hw/dcache_req_port.sv
`timescale 1ns/100ps

module dcache_req_port (
    input  logic                     clk_i,
    input  logic                     rstn_i,
    input  logic                     core_req_valid_i,
    input  dcache_pkg::core_req_t    core_req_i,
    output logic                     core_req_ready_o,
    output logic                     core_rsp_valid_o,
    output dcache_pkg::core_rsp_t    core_rsp_o,
    output logic                     req_valid_o,
    output dcache_pkg::core_req_t    req_o,
    output dcache_pkg::addr_fields_t fields_o,
    input  logic                     done_i,
    input  dcache_pkg::core_rsp_t    rsp_i
);
    import dcache_pkg::*;

    logic         accept;
    logic         busy_q;
    logic         req_valid_q;
    logic         rsp_valid_q;
    core_req_t    req_q;
    addr_fields_t fields_q;
    core_rsp_t    rsp_q;

    assign accept = core_req_valid_i && !busy_q;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            busy_q      <= 1'b0;
            req_valid_q <= 1'b0;
            rsp_valid_q <= 1'b0;
        end else begin
            req_valid_q <= accept;
            rsp_valid_q <= done_i;
            if (accept) begin
                busy_q <= 1'b1;
            end else if (rsp_valid_q) begin
                busy_q <= 1'b0;  // Ready again after the strobe.
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            req_q    <= core_req_i;
            fields_q <= addr_fields_t'(core_req_i.addr);
        end
        if (done_i) begin
            rsp_q <= rsp_i;
        end
    end

    assign core_req_ready_o = !busy_q;
    assign core_rsp_valid_o = rsp_valid_q;
    assign core_rsp_o       = rsp_q;
    assign req_valid_o      = req_valid_q;
    assign req_o            = req_q;
    assign fields_o         = fields_q;

    // One answer per accepted request.
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        done_i |-> busy_q && !rsp_valid_q);

endmodule

//--- hw/dcache_store.sv
`timescale 1ns/100ps
`include "dcache_config.svh"

module dcache_store (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  dcache_pkg::index_t  rd_index_i,
    input  dcache_pkg::tag_t    rd_tag_i,
    output dcache_pkg::lookup_t lookup_o,
    input  logic                wr_en_i,
    input  dcache_pkg::index_t  wr_index_i,
    input  dcache_pkg::way_t    wr_way_i,
    input  dcache_pkg::tag_t    wr_tag_i,
    input  dcache_pkg::line_t   wr_line_i,
    input  logic                wr_valid_i,
    input  logic                wr_dirty_i,
    input  logic                touch_en_i,
    input  dcache_pkg::index_t  touch_index_i,
    input  dcache_pkg::way_t    touch_way_i
);
    import dcache_pkg::*;

    tag_t  tag_q  [`DCACHE_SETS][`DCACHE_WAYS];
    line_t data_q [`DCACHE_SETS][`DCACHE_WAYS];

    logic [`DCACHE_SETS-1:0][`DCACHE_WAYS-1:0] valid_q;
    logic [`DCACHE_SETS-1:0][`DCACHE_WAYS-1:0] dirty_q;
    way_t [`DCACHE_SETS-1:0]                   lru_q;  // Least recently used way.

    logic [`DCACHE_WAYS-1:0] hit_vec;

    always_comb begin
        way_t victim;
        hit_vec  = '0;
        lookup_o = '0;
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            if (valid_q[rd_index_i][w] && (tag_q[rd_index_i][w] == rd_tag_i)) begin
                hit_vec[w]       = 1'b1;
                lookup_o.hit     = 1'b1;
                lookup_o.hit_way = way_t'(w);
            end
        end
        lookup_o.hit_line = data_q[rd_index_i][lookup_o.hit_way];

        victim                = lru_q[rd_index_i];
        lookup_o.victim_way   = victim;
        lookup_o.victim_valid = valid_q[rd_index_i][victim];
        lookup_o.victim_dirty = dirty_q[rd_index_i][victim];
        lookup_o.victim_tag   = tag_q[rd_index_i][victim];
        lookup_o.victim_line  = data_q[rd_index_i][victim];
    end

    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            tag_q[wr_index_i][wr_way_i]  <= wr_tag_i;
            data_q[wr_index_i][wr_way_i] <= wr_line_i;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else begin
            if (wr_en_i) begin
                valid_q[wr_index_i][wr_way_i] <= wr_valid_i;
                dirty_q[wr_index_i][wr_way_i] <= wr_dirty_i;
            end
            // Two ways, so the other one becomes LRU.
            if (touch_en_i) begin
                lru_q[touch_index_i] <= ~touch_way_i;
            end
        end
    end

    // A refill never duplicates a resident tag.
    assert property (@(posedge clk_i) disable iff (!rstn_i) $onehot0(hit_vec));

endmodule

//--- hw/dcache_ctrl.sv
`timescale 1ns/100ps

module dcache_ctrl (
    input  logic                     clk_i,
    input  logic                     rstn_i,
    input  logic                     req_valid_i,
    input  dcache_pkg::core_req_t    req_i,
    input  dcache_pkg::addr_fields_t fields_i,
    output logic                     done_o,
    output dcache_pkg::core_rsp_t    rsp_o,
    input  dcache_pkg::lookup_t      lookup_i,
    output logic                     wr_en_o,
    output dcache_pkg::index_t       wr_index_o,
    output dcache_pkg::way_t         wr_way_o,
    output dcache_pkg::tag_t         wr_tag_o,
    output dcache_pkg::line_t        wr_line_o,
    output logic                     wr_valid_o,
    output logic                     wr_dirty_o,
    output logic                     touch_en_o,
    output dcache_pkg::index_t       touch_index_o,
    output dcache_pkg::way_t         touch_way_o,
    output logic                     mem_start_o,
    output dcache_pkg::mem_req_t     mem_req_o,
    input  logic                     mem_done_i,
    input  dcache_pkg::line_t        mem_line_i
);
    import dcache_pkg::*;

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    way_t        victim_q;
    logic        is_hit;
    logic        need_wb;
    logic        fill;

    assign is_hit  = (state_q == LOOKUP) && lookup_i.hit;
    assign need_wb = lookup_i.victim_valid && lookup_i.victim_dirty;
    assign fill    = (state_q == REFILL) && mem_done_i;

    always_comb begin
        state_d     = state_q;
        mem_start_o = 1'b0;
        case (state_q)
            IDLE: begin
                if (req_valid_i) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (lookup_i.hit) begin
                    state_d = IDLE;
                end else begin
                    mem_start_o = 1'b1;
                    state_d     = need_wb ? WRITE_BACK : REFILL;
                end
            end
            WRITE_BACK: begin
                if (mem_done_i) begin
                    mem_start_o = 1'b1;  // Refill read follows.
                    state_d     = REFILL;
                end
            end
            REFILL: begin
                if (mem_done_i) begin
                    state_d = RESPOND;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == LOOKUP) begin
            victim_q <= lookup_i.victim_way;
        end
    end

    // Writeback only leaves LOOKUP; refill reads use the request address.
    always_comb begin
        mem_req_o.we    = (state_q == LOOKUP) && need_wb;
        mem_req_o.wline = lookup_i.victim_line;
        if (mem_req_o.we) begin
            mem_req_o.addr = {lookup_i.victim_tag, fields_i.index, offset_t'(0)};
        end else begin
            mem_req_o.addr = {fields_i.tag, fields_i.index, offset_t'(0)};
        end
    end

    always_comb begin
        line_t merged;
        if (fill) begin
            merged = mem_line_i;
        end else begin
            merged = lookup_i.hit_line;
        end
        if (req_i.we) begin
            merged[fields_i.offset] = req_i.wdata;
        end
        wr_line_o  = merged;
        wr_en_o    = fill || (is_hit && req_i.we);
        wr_way_o   = fill ? victim_q : lookup_i.hit_way;
        wr_dirty_o = req_i.we;  // Only stores dirty a line.
    end

    assign wr_index_o    = fields_i.index;
    assign wr_tag_o      = fields_i.tag;
    assign wr_valid_o    = 1'b1;
    assign touch_en_o    = is_hit || fill;
    assign touch_index_o = fields_i.index;
    assign touch_way_o   = fill ? victim_q : lookup_i.hit_way;

    // In RESPOND the freshly filled line hits.
    assign done_o      = is_hit || (state_q == RESPOND);
    assign rsp_o.rdata = req_i.we ? '0 : lookup_i.hit_line[fields_i.offset];

    // Memory completions only end a memory phase.
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        mem_done_i |-> state_q inside {WRITE_BACK, REFILL});

endmodule

//--- hw/dcache_mem_port.sv
`timescale 1ns/100ps

module dcache_mem_port (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  logic                 mem_start_i,
    input  dcache_pkg::mem_req_t mem_req_i,
    output logic                 mem_done_o,
    output dcache_pkg::line_t    mem_line_o,
    output logic                 mem_req_valid_o,
    output dcache_pkg::mem_req_t mem_req_o,
    input  logic                 mem_req_ready_i,
    input  logic                 mem_rsp_valid_i,
    input  dcache_pkg::mem_rsp_t mem_rsp_i
);
    import dcache_pkg::*;

    mem_req_t req_q;
    line_t    line_q;
    logic     valid_q;
    logic     wait_q;  // Response pending after acceptance.
    logic     done_q;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q <= 1'b0;
            wait_q  <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            done_q <= mem_rsp_valid_i && wait_q;
            if (mem_start_i) begin
                valid_q <= 1'b1;
            end else if (valid_q && mem_req_ready_i) begin
                valid_q <= 1'b0;
            end
            if (valid_q && mem_req_ready_i) begin
                wait_q <= 1'b1;
            end else if (mem_rsp_valid_i) begin
                wait_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (mem_start_i) begin
            req_q <= mem_req_i;
        end
        if (mem_rsp_valid_i) begin
            line_q <= mem_rsp_i.line;
        end
    end

    assign mem_req_valid_o = valid_q;
    assign mem_req_o       = req_q;
    assign mem_done_o      = done_q;
    assign mem_line_o      = line_q;

    // Stalled request holds.
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_o));

    assert property (@(posedge clk_i) disable iff (!rstn_i)
        mem_rsp_valid_i |-> wait_q);

endmodule

//--- hw/dcache_top.sv
`timescale 1ns/100ps

module dcache_top (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  core_req_valid_i,
    input  dcache_pkg::core_req_t core_req_i,
    output logic                  core_req_ready_o,
    output logic                  core_rsp_valid_o,
    output dcache_pkg::core_rsp_t core_rsp_o,
    output logic                  mem_req_valid_o,
    output dcache_pkg::mem_req_t  mem_req_o,
    input  logic                  mem_req_ready_i,
    input  logic                  mem_rsp_valid_i,
    input  dcache_pkg::mem_rsp_t  mem_rsp_i
);
    import dcache_pkg::*;

    core_req_t    req;
    addr_fields_t fields;
    logic         req_valid;
    logic         done;
    core_rsp_t    rsp;
    lookup_t      lookup;
    logic         wr_en;
    index_t       wr_index;
    way_t         wr_way;
    tag_t         wr_tag;
    line_t        wr_line;
    logic         wr_valid;
    logic         wr_dirty;
    logic         touch_en;
    index_t       touch_index;
    way_t         touch_way;
    logic         mem_start;
    mem_req_t     mem_req;
    logic         mem_done;
    line_t        mem_line;

    dcache_req_port u_req_port (
        .clk_i, .rstn_i, .core_req_valid_i, .core_req_i, .core_req_ready_o,
        .core_rsp_valid_o, .core_rsp_o,
        .req_valid_o (req_valid), .req_o (req), .fields_o (fields),
        .done_i (done), .rsp_i (rsp)
    );

    dcache_ctrl u_ctrl (
        .clk_i, .rstn_i,
        .req_valid_i (req_valid), .req_i (req), .fields_i (fields),
        .done_o (done), .rsp_o (rsp), .lookup_i (lookup),
        .wr_en_o (wr_en), .wr_index_o (wr_index), .wr_way_o (wr_way),
        .wr_tag_o (wr_tag), .wr_line_o (wr_line), .wr_valid_o (wr_valid),
        .wr_dirty_o (wr_dirty), .touch_en_o (touch_en),
        .touch_index_o (touch_index), .touch_way_o (touch_way),
        .mem_start_o (mem_start), .mem_req_o (mem_req),
        .mem_done_i (mem_done), .mem_line_i (mem_line)
    );

    dcache_store u_store (
        .clk_i, .rstn_i,
        .rd_index_i (fields.index), .rd_tag_i (fields.tag), .lookup_o (lookup),
        .wr_en_i (wr_en), .wr_index_i (wr_index), .wr_way_i (wr_way),
        .wr_tag_i (wr_tag), .wr_line_i (wr_line), .wr_valid_i (wr_valid),
        .wr_dirty_i (wr_dirty), .touch_en_i (touch_en),
        .touch_index_i (touch_index), .touch_way_i (touch_way)
    );

    dcache_mem_port u_mem_port (
        .clk_i, .rstn_i,
        .mem_start_i (mem_start), .mem_req_i (mem_req),
        .mem_done_o (mem_done), .mem_line_o (mem_line),
        .mem_req_valid_o, .mem_req_o, .mem_req_ready_i,
        .mem_rsp_valid_i, .mem_rsp_i
    );

endmodule

//--- tb/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 4
) (
    output logic clk_o,
    output logic rstn_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    initial begin
        rstn_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #2 rstn_o = 1'b1;  // Released off the edge.
    end

endmodule

//--- tb/tb_mem_model.sv
`timescale 1ns/100ps

module tb_mem_model (
    input  logic                 clk_i,
    input  logic [31:0]          rnd_i,
    input  logic                 mem_req_valid_i,
    input  dcache_pkg::mem_req_t mem_req_i,
    output logic                 mem_req_ready_o,
    output logic                 mem_rsp_valid_o,
    output dcache_pkg::mem_rsp_t mem_rsp_o
);
    import dcache_pkg::*;

    localparam word_t FILL = 32'h5a5a0000;

    word_t mem [word_t];  // Untouched words read as the fill pattern.

    function automatic word_t read_word(input word_t addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return addr ^ FILL;
    endfunction

    initial begin
        mem_req_t req;
        int       delay;
        logic     taken;
        logic     stall;
        mem_req_ready_o = 1'b0;
        mem_rsp_valid_o = 1'b0;
        mem_rsp_o       = '0;
        forever begin
            @(posedge clk_i);
            taken = mem_req_valid_i && mem_req_ready_o;
            req   = mem_req_i;
            delay = rnd_i[3:0] % 6;
            stall = (rnd_i[5:4] == 2'b00);  // One cycle in four.
            #2;
            mem_rsp_valid_o = 1'b0;
            mem_req_ready_o = !stall;
            if (taken) begin
                mem_req_ready_o = 1'b0;
                if (delay > 0) begin
                    repeat (delay) @(posedge clk_i);
                    #2;
                end
                for (int i = 0; i < 4; i++) begin
                    if (req.we) begin
                        mem[req.addr + i] = req.wline[i];
                    end
                    mem_rsp_o.line[i] = read_word(req.addr + i);
                end
                mem_rsp_valid_o = 1'b1;
            end
        end
    end

endmodule

//--- tb/dcache_tb.sv
`timescale 1ns/100ps
`include "dcache_config.svh"

module dcache_tb;
    import dcache_pkg::*;

    localparam int          REQ_TOTAL       = 214;
    localparam int          WATCHDOG_CYCLES = 400 * REQ_TOTAL;
    localparam logic [31:0] SEED            = 32'd19277;
    localparam word_t       FILL            = 32'h5a5a0000;
    localparam int          REF_WORDS       = 1024;

    // Expected kind of the outstanding request.
    localparam int ANY     = 0;
    localparam int HIT     = 1;
    localparam int MISS    = 2;
    localparam int MISS_WB = 3;

    logic        clk;
    logic        rstn;
    logic        core_req_valid;
    core_req_t   core_req;
    logic        core_req_ready;
    logic        core_rsp_valid;
    core_rsp_t   core_rsp;
    logic        mem_req_valid;
    mem_req_t    mem_req;
    logic        mem_req_ready;
    logic        mem_rsp_valid;
    mem_rsp_t    mem_rsp;
    logic [31:0] mem_rnd;
    logic [31:0] stim_rnd;

    word_t ref_mem [REF_WORDS];  // Word-addressed reference memory.
    int    exp_mode;
    word_t exp_rdata;
    word_t exp_line;
    word_t exp_wb_addr;
    int    rd_cnt;
    int    wr_cnt;
    int    errors;
    int    errors_at_start;
    int    tests_run;
    int    responses;
    string test_name;

    logic accept;
    logic mem_rd_hs;
    logic mem_wr_hs;

    assign accept    = core_req_valid && core_req_ready;
    assign mem_rd_hs = mem_req_valid && mem_req_ready && !mem_req.we;
    assign mem_wr_hs = mem_req_valid && mem_req_ready && mem_req.we;

    tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(4)) u_clock_gen (.clk_o(clk), .rstn_o(rstn));

    dcache_top u_dcache_top (
        .clk_i (clk), .rstn_i (rstn),
        .core_req_valid_i (core_req_valid), .core_req_i (core_req),
        .core_req_ready_o (core_req_ready),
        .core_rsp_valid_o (core_rsp_valid), .core_rsp_o (core_rsp),
        .mem_req_valid_o (mem_req_valid), .mem_req_o (mem_req),
        .mem_req_ready_i (mem_req_ready),
        .mem_rsp_valid_i (mem_rsp_valid), .mem_rsp_i (mem_rsp)
    );

    tb_mem_model u_mem_model (
        .clk_i (clk), .rnd_i (mem_rnd),
        .mem_req_valid_i (mem_req_valid), .mem_req_i (mem_req),
        .mem_req_ready_o (mem_req_ready),
        .mem_rsp_valid_o (mem_rsp_valid), .mem_rsp_o (mem_rsp)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        stim_rnd = xorshift32(stim_rnd);
        return stim_rnd;
    endfunction

    function automatic word_t make_addr(input int tag, input int set, input int off);
        return word_t'((tag << 6) | (set << 2) | off);
    endfunction

    function automatic line_t ref_line(input word_t addr);
        line_t line;
        for (int i = 0; i < `DCACHE_WORDS; i++) begin
            line[i] = ref_mem[addr[9:0] + i];
        end
        return line;
    endfunction

    // Memory handshakes since the last accepted request.
    always @(posedge clk) begin
        mem_rnd <= xorshift32(mem_rnd);
        if (accept) begin
            rd_cnt <= 0;
            wr_cnt <= 0;
        end else begin
            if (mem_rd_hs) begin
                rd_cnt <= rd_cnt + 1;
            end
            if (mem_wr_hs) begin
                wr_cnt <= wr_cnt + 1;
            end
        end
        if (core_rsp_valid) begin
            responses <= responses + 1;
        end
    end

    assert property (@(posedge clk) $rose(rstn) |->
        core_req_ready && !core_rsp_valid && !mem_req_valid)
    else begin
        errors++;
        $display("outputs were not idle when reset was released");
    end

    assert property (@(posedge clk) disable iff (!rstn)
        core_rsp_valid |-> core_rsp.rdata == exp_rdata)
    else begin
        errors++;
        $display("mismatch %s: read data expected %h, actual %h",
                 test_name, exp_rdata, core_rsp.rdata);
    end

    assert property (@(posedge clk) disable iff (!rstn)
        accept && exp_mode == HIT |->
            ##1 (!core_rsp_valid && !mem_req_valid) [*2] ##1 (core_rsp_valid && !mem_req_valid))
    else begin
        errors++;
        $display("%s: hit did not answer 2 cycles after acceptance without memory traffic",
                 test_name);
    end

    assert property (@(posedge clk) disable iff (!rstn)
        core_rsp_valid && exp_mode >= MISS |->
            rd_cnt == 1 && wr_cnt == ((exp_mode == MISS_WB) ? 1 : 0))
    else begin
        errors++;
        $display("mismatch %s: memory reads/writes expected 1/%0d, actual %0d/%0d",
                 test_name, (exp_mode == MISS_WB) ? 1 : 0, rd_cnt, wr_cnt);
    end

    assert property (@(posedge clk) disable iff (!rstn)
        mem_rd_hs |-> mem_req.addr == exp_line)
    else begin
        errors++;
        $display("mismatch %s: refill address expected %h, actual %h",
                 test_name, exp_line, mem_req.addr);
    end

    assert property (@(posedge clk) disable iff (!rstn)
        mem_wr_hs && exp_mode == MISS_WB |-> mem_req.addr == exp_wb_addr)
    else begin
        errors++;
        $display("mismatch %s: writeback address expected %h, actual %h",
                 test_name, exp_wb_addr, mem_req.addr);
    end

    assert property (@(posedge clk) disable iff (!rstn)
        mem_wr_hs |-> mem_req.wline == ref_line(mem_req.addr))
    else begin
        errors++;
        $display("mismatch %s: writeback line expected %h, actual %h",
                 test_name, ref_line(mem_req.addr), mem_req.wline);
    end

    task automatic issue(input word_t addr, input logic we, input word_t wdata,
                         input int mode, input word_t wb_addr);
        @(posedge clk);
        #2;
        exp_mode    = mode;
        exp_line    = {addr[31:2], 2'b00};
        exp_wb_addr = wb_addr;
        exp_rdata   = we ? '0 : ref_mem[addr[9:0]];
        if (we) begin
            ref_mem[addr[9:0]] = wdata;
        end
        core_req_valid = 1'b1;
        core_req       = '{addr: addr, wdata: wdata, we: we};
        @(posedge clk);
        while (!core_req_ready) begin
            @(posedge clk);
        end
        #2;
        core_req_valid = 1'b0;
        @(posedge clk);
        while (!core_rsp_valid) begin
            @(posedge clk);
        end
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        @(negedge clk);  // Let the edge's checks settle.
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %s passed", test_name);
        end else begin
            $display("test %s failed with %0d errors", test_name, errors - errors_at_start);
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles, the cache stopped answering", WATCHDOG_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        logic [31:0] r;
        core_req_valid = 1'b0;
        core_req       = '0;
        mem_rnd        = SEED;
        stim_rnd       = SEED;
        exp_mode       = ANY;
        exp_rdata      = '0;
        exp_line       = '0;
        exp_wb_addr    = '0;
        rd_cnt         = 0;
        wr_cnt         = 0;
        errors         = 0;
        tests_run      = 0;
        responses      = 0;
        for (int i = 0; i < REF_WORDS; i++) begin
            ref_mem[i] = word_t'(i) ^ FILL;
        end

        start_test("reset");
        wait (rstn === 1'b1);
        repeat (2) @(posedge clk);
        end_test();

        start_test("read_miss");
        issue(make_addr(1, 2, 3), 1'b0, '0, MISS, '0);
        end_test();

        start_test("write_hit");
        issue(make_addr(1, 3, 1), 1'b0, '0, MISS, '0);
        issue(make_addr(1, 3, 1), 1'b1, 32'hcafe0011, HIT, '0);
        issue(make_addr(1, 3, 1), 1'b0, '0, HIT, '0);
        end_test();

        // A dirty, then B and C evict it.
        start_test("writeback");
        issue(make_addr(1, 6, 2), 1'b1, 32'h0badf00d, MISS, '0);
        issue(make_addr(2, 6, 0), 1'b0, '0, MISS, '0);
        issue(make_addr(3, 6, 1), 1'b0, '0, MISS_WB, make_addr(1, 6, 0));
        issue(make_addr(1, 6, 2), 1'b0, '0, MISS, '0);
        end_test();

        start_test("lru");
        issue(make_addr(1, 5, 0), 1'b0, '0, MISS, '0);
        issue(make_addr(2, 5, 0), 1'b0, '0, MISS, '0);
        issue(make_addr(1, 5, 0), 1'b0, '0, HIT, '0);
        issue(make_addr(3, 5, 0), 1'b0, '0, MISS, '0);  // Evicts B.
        issue(make_addr(1, 5, 0), 1'b0, '0, HIT, '0);
        issue(make_addr(2, 5, 0), 1'b0, '0, MISS, '0);
        end_test();

        // Four tags in each of sets 8 to 11.
        start_test("random");
        for (int n = 0; n < 200; n++) begin
            r = next_rand();
            issue(make_addr(r[1:0], 8 + r[3:2], r[5:4]), r[6], next_rand(), ANY, '0);
        end
        end_test();

        $display("tests %0d, responses %0d, errors %0d", tests_run, responses, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+hw
hw/dcache_pkg.sv
hw/dcache_req_port.sv
hw/dcache_store.sv
hw/dcache_ctrl.sv
hw/dcache_mem_port.sv
hw/dcache_top.sv
tb/tb_clock_gen.sv
tb/tb_mem_model.sv
tb/dcache_tb.sv
